/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = proc_tb
FILELIST = proc.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/proc_assertions.sv */
// ####################
// Processor assertions
// Halt, fetch and writeback properties bound into the top level
// ####################
`timescale 1ns/1ps

module proc_assertions (
	input logic clk,
	input logic rst_n,
	input proc_pkg::word_t imem_addr,
	input logic wb_en,
	input proc_pkg::reg_sel_t wb_reg,
	input logic halted
);

	// Nothing retires once HALT has gone through
	no_write_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
		halted |-> !wb_en)
		else $error("wb_en high while halted");

	halted_is_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted)
		else $error("halted fell without reset");

	// Fetch is frozen well before halted rises
	fetch_frozen: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> $stable(imem_addr))
		else $error("imem_addr moved while halted");

	wb_reg_known: assert property (@(posedge clk) disable iff (!rst_n)
		wb_en |-> !$isunknown(wb_reg))
		else $error("wb_reg unknown during a writeback");

endmodule

bind proc proc_assertions assertions_i (
	.clk(clk),
	.rst_n(rst_n),
	.imem_addr(imem_addr),
	.wb_en(wb_en),
	.wb_reg(wb_reg),
	.halted(halted)
);

/* bench/proc_tb.sv */
// ####################
// Processor testbench
// Directed programs run against an in-order reference model,
// with per-cycle checks of fetch, writeback, err and halted
// ####################
`timescale 1ns/1ps

module proc_tb;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	localparam int PROG_MAX = 64;
	localparam int IMEM_WORDS = 64;
	localparam int TAIL_CYCLES = 6;
	localparam int NUM_TESTS = 6;
	localparam int RUN_MARGIN = 24;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * (PROG_MAX + RUN_MARGIN);

	localparam logic [4:0] OPC_HALT = 5'b00000;
	localparam logic [4:0] OPC_NOP = 5'b00001;
	localparam logic [4:0] OPC_ADDI = 5'b01000;
	localparam logic [4:0] OPC_SUBI = 5'b01001;
	localparam logic [4:0] OPC_SLBI = 5'b10010;
	localparam logic [4:0] OPC_LBI = 5'b11000;
	localparam logic [4:0] OPC_RTYPE = 5'b11011;
	localparam logic [15:0] NOP_WORD = {OPC_NOP, 11'd0};
	localparam logic [15:0] HALT_WORD = {OPC_HALT, 11'd0};
	localparam logic [15:0] IMEM_BYTES = 16'd128;

	logic clk = 1'b0;
	logic rst_n;
	logic [15:0] imem_data;
	logic [15:0] imem_addr;
	logic wb_en;
	logic [2:0] wb_reg;
	logic [15:0] wb_data;
	logic halted;
	logic err;

	logic [15:0] imem [0:IMEM_WORDS-1];
	logic [15:0] prog [0:PROG_MAX-1];
	logic exp_wr [0:PROG_MAX-1];
	logic [2:0] exp_reg [0:PROG_MAX-1];
	logic [15:0] exp_data [0:PROG_MAX-1];
	int prog_len = 0;
	int halt_idx = 0;
	int exp_count = 0;
	int wb_seen = 0;
	int cycle = 0;
	int checks = 0;
	int errors = 0;

	proc dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.imem_data(imem_data),
		.imem_addr(imem_addr),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.halted(halted),
		.err(err)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Instruction memory, NOP outside the loaded range
	assign imem_data = (imem_addr < IMEM_BYTES) ? imem[imem_addr[6:1]] : NOP_WORD;

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR @%0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	function automatic logic [15:0] sext5(input logic [4:0] v);
		return {{11{v[4]}}, v};
	endfunction

	function automatic logic [15:0] sext8(input logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	function automatic logic is_defined(input logic [4:0] op);
		case (op)
			OPC_HALT, OPC_NOP, OPC_ADDI, OPC_SUBI, OPC_SLBI, OPC_LBI, OPC_RTYPE: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [15:0] enc_imm(input logic [4:0] op, input logic [2:0] rs,
		input logic [2:0] rt, input logic [4:0] imm5);
		return {op, rs, rt, imm5};
	endfunction

	function automatic logic [15:0] enc_byte(input logic [4:0] op, input logic [2:0] rs,
		input logic [7:0] imm8);
		return {op, rs, imm8};
	endfunction

	function automatic logic [15:0] enc_reg(input logic [2:0] rs, input logic [2:0] rt,
		input logic [2:0] rd, input logic [1:0] funct);
		return {OPC_RTYPE, rs, rt, rd, funct};
	endfunction

	task automatic add_instr(input logic [15:0] instr);
		if (prog_len >= PROG_MAX) begin
			errors++;
			$display("Program longer than %0d instructions, instruction dropped", PROG_MAX);
		end else begin
			prog[prog_len] = instr;
			prog_len++;
		end
	endtask

	task automatic add_nops(input int n);
		for (int i = 0; i < n; i++) begin
			add_instr(NOP_WORD);
		end
	endtask

	// LBI gives the high byte, SLBI shifts it up and adds the low byte
	task automatic load_const(input logic [2:0] r, input logic [15:0] value);
		add_instr(enc_byte(OPC_LBI, r, value[15:8]));
		add_instr(enc_byte(OPC_SLBI, r, value[7:0]));
	endtask

	// In-order model over eight registers, one entry per instruction
	task automatic build_expected();
		logic [15:0] regs [0:7];
		logic [15:0] ins;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic [2:0] dst;
		logic wr;
		halt_idx = -1;
		exp_count = 0;
		for (int r = 0; r < 8; r++) begin
			regs[r] = 16'h0000;
		end
		for (int i = 0; i < prog_len && halt_idx < 0; i++) begin
			ins = prog[i];
			a = regs[ins[10:8]];
			b = regs[ins[7:5]];
			dst = ins[7:5];
			res = 16'h0000;
			wr = 1'b1;
			case (ins[15:11])
				OPC_HALT: begin
					wr = 1'b0;
					halt_idx = i;
				end
				OPC_ADDI: res = a + sext5(ins[4:0]);
				OPC_SUBI: res = sext5(ins[4:0]) - a;
				OPC_LBI: begin
					dst = ins[10:8];
					res = sext8(ins[7:0]);
				end
				OPC_SLBI: begin
					dst = ins[10:8];
					res = (a << 8) | {8'h00, ins[7:0]};
				end
				OPC_RTYPE: begin
					dst = ins[4:2];
					case (ins[1:0])
						2'b00: res = a + b;
						2'b01: res = b - a;
						2'b10: res = a ^ b;
						default: res = a & ~b;
					endcase
				end
				// NOP and undefined opcodes
				default: wr = 1'b0;
			endcase
			exp_wr[i] = wr;
			exp_reg[i] = dst;
			exp_data[i] = res;
			if (wr) begin
				regs[dst] = res;
				exp_count++;
			end
		end
		if (halt_idx < 0) begin
			errors++;
			$display("Program has no HALT instruction");
		end
	endtask

	// Put the DUT in reset before the program and the model change
	task automatic open_program();
		@(posedge clk);
		#1;
		rst_n = 1'b0;
		prog_len = 0;
	endtask

	task automatic launch_program();
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = (i < prog_len) ? prog[i] : NOP_WORD;
		end
		build_expected();
		wb_seen = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	task automatic finish_program(input string name);
		wait (halted === 1'b1);
		repeat (TAIL_CYCLES) @(negedge clk);
		check_eq(32'(wb_seen), 32'(exp_count), {name, " writeback count"});
	endtask

	// Cycle 0 is the first cycle with rst_n high
	always @(negedge clk) begin
		int idx;
		int exp_addr;
		logic exp_en;
		logic exp_err;
		if (!rst_n) begin
			cycle = 0;
			check_eq(32'(wb_en), 0, "wb_en in reset");
			check_eq(32'(halted), 0, "halted in reset");
			check_eq(32'(err), 0, "err in reset");
		end else begin
			// PC holds once HALT reaches decode
			exp_addr = 2 * ((cycle < halt_idx + 1) ? cycle : halt_idx + 1);
			check_eq(32'(imem_addr), 32'(exp_addr), "fetch address");
			exp_err = (cycle >= 1 && cycle - 1 <= halt_idx) ?
				!is_defined(prog[cycle - 1][15:11]) : 1'b0;
			check_eq(32'(err), 32'(exp_err), "err flag");
			check_eq(32'(halted), 32'(cycle >= halt_idx + 5), "halted flag");
			idx = cycle - 4;
			exp_en = (idx >= 0 && idx < halt_idx) ? exp_wr[idx] : 1'b0;
			check_eq(32'(wb_en), 32'(exp_en), "wb_en");
			if (wb_en === 1'b1 && exp_en) begin
				check_eq(32'(wb_reg), 32'(exp_reg[idx]), "wb_reg");
				check_eq(32'(wb_data), 32'(exp_data[idx]), "wb_data");
			end
			if (wb_en === 1'b1) begin
				wb_seen++;
			end
			cycle++;
		end
	end

	task automatic test_reset();
		logic [31:0] r;
		int edges;
		open_program();
		r = $urandom();
		add_instr(enc_byte(OPC_LBI, 3'd1, r[7:0]));
		add_instr(HALT_WORD);
		launch_program();
		@(negedge clk);
		check_eq(32'(imem_addr), 0, "first fetch address");
		// LBI writes back four edges after its fetch
		edges = 0;
		while (wb_en !== 1'b1 && edges < 8) begin
			@(negedge clk);
			edges++;
		end
		check_eq(32'(edges), 4, "edges to first writeback");
		finish_program("reset");
	endtask

	task automatic test_constants();
		logic [31:0] r;
		open_program();
		for (int i = 0; i < 8; i++) begin
			r = $urandom();
			load_const(3'(i), r[15:0]);
		end
		add_instr(HALT_WORD);
		launch_program();
		finish_program("constants");
	endtask

	task automatic test_alu();
		logic [31:0] r;
		open_program();
		for (int i = 1; i < 5; i++) begin
			r = $urandom();
			load_const(3'(i), r[15:0]);
		end
		r = $urandom();
		add_instr(enc_imm(OPC_ADDI, 3'd1, 3'd5, r[4:0]));
		add_instr(enc_imm(OPC_SUBI, 3'd2, 3'd6, r[9:5]));
		for (int f = 0; f < 4; f++) begin
			r = $urandom();
			add_instr(enc_reg(r[2:0], r[5:3], r[8:6], 2'(f)));
		end
		for (int k = 0; k < 4; k++) begin
			r = $urandom();
			add_instr(enc_imm(k[0] ? OPC_SUBI : OPC_ADDI, r[2:0], r[5:3], r[10:6]));
		end
		add_instr(HALT_WORD);
		launch_program();
		finish_program("alu");
	endtask

	// Distance 1 is EX-EX, 2 is MEM-EX, 3 goes through the register file
	task automatic test_forwarding();
		logic [31:0] r;
		open_program();
		r = $urandom();
		load_const(3'd4, r[15:0]);
		for (int d = 1; d <= 3; d++) begin
			r = $urandom();
			add_instr(enc_byte(OPC_LBI, 3'd1, r[7:0]));
			add_nops(d - 1);
			add_instr(enc_imm(OPC_ADDI, 3'd1, 3'd2, r[12:8]));
			add_nops(d - 1);
			// Operand B from the producer
			add_instr(enc_reg(3'd4, 3'd2, 3'd3, r[14:13]));
			add_nops(d - 1);
			add_instr(enc_byte(OPC_SLBI, 3'd3, r[23:16]));
			add_instr(enc_reg(3'd3, 3'd3, 3'd5, r[25:24]));
		end
		add_instr(HALT_WORD);
		launch_program();
		finish_program("forwarding");
	endtask

	task automatic test_halt();
		logic [31:0] r;
		open_program();
		r = $urandom();
		load_const(3'd6, r[15:0]);
		add_instr(enc_imm(OPC_ADDI, 3'd6, 3'd7, r[20:16]));
		add_instr(HALT_WORD);
		// None of these may retire
		for (int i = 0; i < 4; i++) begin
			r = $urandom();
			add_instr(enc_byte(OPC_LBI, 3'(i), r[7:0]));
		end
		launch_program();
		finish_program("halt");
	endtask

	task automatic test_undefined();
		logic [31:0] r;
		open_program();
		r = $urandom();
		add_instr(enc_byte(OPC_LBI, 3'd1, r[7:0]));
		add_instr({5'b11111, r[18:8]});
		add_instr(enc_imm(OPC_ADDI, 3'd1, 3'd2, r[23:19]));
		// Fields that would name r2 as a destination
		add_instr({5'b00010, 3'd2, 3'd2, 5'd0});
		add_instr({5'b10000, r[31:21]});
		add_instr(enc_reg(3'd2, 3'd1, 3'd3, 2'b01));
		add_instr(HALT_WORD);
		launch_program();
		finish_program("undefined");
	endtask

	initial begin
		void'($urandom(32'h935f3807));
		rst_n = 1'b0;
		for (int i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = NOP_WORD;
		end
		test_reset();
		test_constants();
		test_alu();
		test_forwarding();
		test_halt();
		test_undefined();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("Checks: %0d, errors: %0d", checks, errors);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* logic/decode_stage.sv */
// ####################
// Decode stage
// Field split, control decode, immediates and the decode/execute register
// ####################
`timescale 1ns/1ps
`include "proc_defines.svh"

module decode_stage (
	input logic clk,
	input logic rst_n,
	input proc_pkg::instr_t fd_instr,
	input proc_pkg::word_t rs_data,
	input proc_pkg::word_t rt_data,
	output proc_pkg::reg_sel_t rs_sel,
	output proc_pkg::reg_sel_t rt_sel,
	output logic halt_decoded,
	output logic err,
	output proc_pkg::alu_op_e x_op,
	output proc_pkg::word_t x_a,
	output proc_pkg::word_t x_b,
	output logic x_b_is_reg,
	output proc_pkg::reg_sel_t x_rs,
	output proc_pkg::reg_sel_t x_rt,
	output proc_pkg::reg_sel_t x_rd,
	output logic x_wr_en,
	output logic x_halt
);

	proc_pkg::opcode_e opcode;
	logic [`PROC_FUNCT_W-1:0] funct;
	proc_pkg::reg_sel_t rd_sel;
	logic [`PROC_IMM5_W-1:0] imm5;
	logic [`PROC_IMM8_W-1:0] imm8;
	proc_pkg::reg_sel_t dst_sel;
	proc_pkg::alu_op_e op;
	proc_pkg::word_t b_val;
	logic b_is_reg;
	logic wr_en;

	assign opcode = proc_pkg::opcode_e'(fd_instr[`PROC_OPC_LSB +: `PROC_OPCODE_W]);
	assign funct = fd_instr[`PROC_FUNCT_W-1:0];
	assign rs_sel = fd_instr[`PROC_RS_LSB +: `PROC_REG_SEL_W];
	assign rt_sel = fd_instr[`PROC_RT_LSB +: `PROC_REG_SEL_W];
	assign rd_sel = fd_instr[`PROC_RD_LSB +: `PROC_REG_SEL_W];
	assign imm5 = fd_instr[`PROC_IMM5_W-1:0];
	assign imm8 = fd_instr[`PROC_IMM8_W-1:0];

	assign halt_decoded = (opcode == proc_pkg::OP_HALT);

	always_comb begin
		op = proc_pkg::ALU_ADD;
		wr_en = 1'b1;
		dst_sel = rt_sel;
		b_is_reg = 1'b0;
		b_val = {{(`PROC_WORD_W - `PROC_IMM5_W){imm5[`PROC_IMM5_W-1]}}, imm5};
		err = 1'b0;
		case (opcode)
			proc_pkg::OP_HALT,
			proc_pkg::OP_NOP: wr_en = 1'b0;
			proc_pkg::OP_ADDI: op = proc_pkg::ALU_ADD;
			// imm5 - Rs
			proc_pkg::OP_SUBI: op = proc_pkg::ALU_RSUB;
			proc_pkg::OP_LBI: begin
				op = proc_pkg::ALU_PASS_B;
				dst_sel = rs_sel;
				b_val = {{(`PROC_WORD_W - `PROC_IMM8_W){imm8[`PROC_IMM8_W-1]}}, imm8};
			end
			proc_pkg::OP_SLBI: begin
				op = proc_pkg::ALU_SLBI;
				dst_sel = rs_sel;
				b_val = {{(`PROC_WORD_W - `PROC_IMM8_W){1'b0}}, imm8};
			end
			proc_pkg::OP_RTYPE: begin
				dst_sel = rd_sel;
				b_is_reg = 1'b1;
				b_val = rt_data;
				case (funct)
					2'b00: op = proc_pkg::ALU_ADD;
					2'b01: op = proc_pkg::ALU_RSUB;
					2'b10: op = proc_pkg::ALU_XOR;
					default: op = proc_pkg::ALU_ANDN;
				endcase
			end
			// Undefined opcode goes on as a bubble
			default: begin
				wr_en = 1'b0;
				err = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			x_op <= proc_pkg::ALU_ADD;
			x_b_is_reg <= 1'b0;
			x_rs <= '0;
			x_rt <= '0;
			x_rd <= '0;
			x_wr_en <= 1'b0;
			x_halt <= 1'b0;
		end else begin
			x_op <= op;
			x_b_is_reg <= b_is_reg;
			x_rs <= rs_sel;
			x_rt <= rt_sel;
			x_rd <= dst_sel;
			x_wr_en <= wr_en;
			x_halt <= halt_decoded;
		end
	end

	// Operand values
	always_ff @(posedge clk) begin
		x_a <= rs_data;
		x_b <= b_val;
	end

endmodule

/* logic/execute_stage.sv */
// ####################
// Execute stage
// Forwarding muxes, ALU and the execute/memory register
// ####################
`timescale 1ns/1ps
`include "proc_defines.svh"

module execute_stage (
	input logic clk,
	input logic rst_n,
	input proc_pkg::alu_op_e x_op,
	input proc_pkg::word_t x_a,
	input proc_pkg::word_t x_b,
	input logic x_wr_en,
	input proc_pkg::reg_sel_t x_rd,
	input logic x_halt,
	input proc_pkg::fwd_sel_e fwd_a,
	input proc_pkg::fwd_sel_e fwd_b,
	input proc_pkg::word_t wb_data,
	output logic m_wr_en,
	output proc_pkg::reg_sel_t m_rd,
	output proc_pkg::word_t m_result,
	output logic m_halt
);

	proc_pkg::word_t a;
	proc_pkg::word_t b;
	proc_pkg::word_t alu_out;

	function automatic proc_pkg::word_t operand_mux(
		input proc_pkg::fwd_sel_e sel,
		input proc_pkg::word_t own,
		input proc_pkg::word_t mem_val,
		input proc_pkg::word_t wb_val
	);
		case (sel)
			proc_pkg::FWD_MEM: return mem_val;
			proc_pkg::FWD_WB: return wb_val;
			default: return own;
		endcase
	endfunction

	assign a = operand_mux(fwd_a, x_a, m_result, wb_data);
	assign b = operand_mux(fwd_b, x_b, m_result, wb_data);

	always_comb begin
		case (x_op)
			proc_pkg::ALU_ADD: alu_out = a + b;
			proc_pkg::ALU_RSUB: alu_out = b - a;
			proc_pkg::ALU_XOR: alu_out = a ^ b;
			proc_pkg::ALU_ANDN: alu_out = a & ~b;
			// Low byte of Rs moves up, imm8 fills the bottom
			proc_pkg::ALU_SLBI: alu_out = {a[`PROC_WORD_W-`PROC_IMM8_W-1:0],
				b[`PROC_IMM8_W-1:0]};
			default: alu_out = b;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_wr_en <= 1'b0;
			m_rd <= '0;
			m_halt <= 1'b0;
		end else begin
			m_wr_en <= x_wr_en;
			m_rd <= x_rd;
			m_halt <= x_halt;
		end
	end

	always_ff @(posedge clk) begin
		m_result <= alu_out;
	end

endmodule

/* logic/fetch_stage.sv */
// ####################
// Fetch stage
// PC counter, freeze FSM and the fetch/decode register
// ####################
`timescale 1ns/1ps
`include "proc_defines.svh"

module fetch_stage (
	input logic clk,
	input logic rst_n,
	input proc_pkg::instr_t imem_data,
	input logic halt_decoded,
	output proc_pkg::word_t imem_addr,
	output proc_pkg::instr_t fd_instr
);

	// Bubble fed to decode after reset and once frozen
	localparam proc_pkg::instr_t NOP_INSTR =
		{proc_pkg::OP_NOP, {(`PROC_WORD_W - `PROC_OPCODE_W){1'b0}}};

	proc_pkg::fetch_state_e state;
	proc_pkg::word_t pc;
	logic run;

	// HALT in decode already blocks this edge
	assign run = (state == proc_pkg::FETCH_RUN) && !halt_decoded;
	assign imem_addr = pc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= proc_pkg::FETCH_RUN;
		end else begin
			case (state)
				proc_pkg::FETCH_RUN: begin
					if (halt_decoded) begin
						state <= proc_pkg::FETCH_FROZEN;
					end
				end
				// Only reset leaves the frozen state
				default: state <= proc_pkg::FETCH_FROZEN;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc <= proc_pkg::word_t'(`PROC_RESET_PC);
			fd_instr <= NOP_INSTR;
		end else if (run) begin
			pc <= pc + proc_pkg::word_t'(`PROC_PC_STEP);
			fd_instr <= imem_data;
		end else begin
			fd_instr <= NOP_INSTR;
		end
	end

endmodule

/* logic/forward_unit.sv */
// ####################
// Forwarding unit
// Picks each execute operand's source from the later stages
// ####################
`timescale 1ns/1ps
`include "proc_defines.svh"

module forward_unit (
	input proc_pkg::reg_sel_t x_rs,
	input proc_pkg::reg_sel_t x_rt,
	input logic x_b_is_reg,
	input logic m_wr_en,
	input proc_pkg::reg_sel_t m_rd,
	input logic wb_en,
	input proc_pkg::reg_sel_t wb_reg,
	output proc_pkg::fwd_sel_e fwd_a,
	output proc_pkg::fwd_sel_e fwd_b
);

	// Younger producer in memory beats the one in writeback
	function automatic proc_pkg::fwd_sel_e pick_source(
		input proc_pkg::reg_sel_t src,
		input logic mem_en,
		input proc_pkg::reg_sel_t mem_dst,
		input logic wr_en,
		input proc_pkg::reg_sel_t wr_dst
	);
		if (mem_en && mem_dst == src) begin
			return proc_pkg::FWD_MEM;
		end else if (wr_en && wr_dst == src) begin
			return proc_pkg::FWD_WB;
		end
		return proc_pkg::FWD_NONE;
	endfunction

	assign fwd_a = pick_source(x_rs, m_wr_en, m_rd, wb_en, wb_reg);

	// Immediate operands never forward
	assign fwd_b = x_b_is_reg ? pick_source(x_rt, m_wr_en, m_rd, wb_en, wb_reg)
		: proc_pkg::FWD_NONE;

endmodule

/* logic/proc.sv */
// ####################
// 16-bit pipelined processor
// Fetch, decode, execute, memory and writeback with operand forwarding
// ####################
`timescale 1ns/1ps
`include "proc_defines.svh"

module proc (
	input logic clk,
	input logic rst_n,
	input proc_pkg::instr_t imem_data,
	output proc_pkg::word_t imem_addr,
	output logic wb_en,
	output proc_pkg::reg_sel_t wb_reg,
	output proc_pkg::word_t wb_data,
	output logic halted,
	output logic err
);

	// Fetch to decode
	proc_pkg::instr_t fd_instr;
	logic halt_decoded;

	// Register file reads
	proc_pkg::reg_sel_t rs_sel;
	proc_pkg::reg_sel_t rt_sel;
	proc_pkg::word_t rs_data;
	proc_pkg::word_t rt_data;

	// Decode/execute register
	proc_pkg::alu_op_e x_op;
	proc_pkg::word_t x_a;
	proc_pkg::word_t x_b;
	logic x_b_is_reg;
	proc_pkg::reg_sel_t x_rs;
	proc_pkg::reg_sel_t x_rt;
	proc_pkg::reg_sel_t x_rd;
	logic x_wr_en;
	logic x_halt;

	proc_pkg::fwd_sel_e fwd_a;
	proc_pkg::fwd_sel_e fwd_b;

	// Execute/memory register
	logic m_wr_en;
	proc_pkg::reg_sel_t m_rd;
	proc_pkg::word_t m_result;
	logic m_halt;

	fetch_stage u_fetch (
		.clk(clk),
		.rst_n(rst_n),
		.imem_data(imem_data),
		.halt_decoded(halt_decoded),
		.imem_addr(imem_addr),
		.fd_instr(fd_instr)
	);

	decode_stage u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.fd_instr(fd_instr),
		.rs_data(rs_data),
		.rt_data(rt_data),
		.rs_sel(rs_sel),
		.rt_sel(rt_sel),
		.halt_decoded(halt_decoded),
		.err(err),
		.x_op(x_op),
		.x_a(x_a),
		.x_b(x_b),
		.x_b_is_reg(x_b_is_reg),
		.x_rs(x_rs),
		.x_rt(x_rt),
		.x_rd(x_rd),
		.x_wr_en(x_wr_en),
		.x_halt(x_halt)
	);

	reg_file u_rf (
		.clk(clk),
		.rst_n(rst_n),
		.rs_sel(rs_sel),
		.rt_sel(rt_sel),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.rs_data(rs_data),
		.rt_data(rt_data)
	);

	forward_unit u_fwd (
		.x_rs(x_rs),
		.x_rt(x_rt),
		.x_b_is_reg(x_b_is_reg),
		.m_wr_en(m_wr_en),
		.m_rd(m_rd),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	execute_stage u_execute (
		.clk(clk),
		.rst_n(rst_n),
		.x_op(x_op),
		.x_a(x_a),
		.x_b(x_b),
		.x_wr_en(x_wr_en),
		.x_rd(x_rd),
		.x_halt(x_halt),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b),
		.wb_data(wb_data),
		.m_wr_en(m_wr_en),
		.m_rd(m_rd),
		.m_result(m_result),
		.m_halt(m_halt)
	);

	retire_stage u_retire (
		.clk(clk),
		.rst_n(rst_n),
		.m_wr_en(m_wr_en),
		.m_rd(m_rd),
		.m_result(m_result),
		.m_halt(m_halt),
		.wb_en(wb_en),
		.wb_reg(wb_reg),
		.wb_data(wb_data),
		.halted(halted)
	);

endmodule

/* logic/proc_defines.svh */
// ####################
// Processor constants
// Widths, instruction field positions and fetch constants
// ####################
`ifndef PROC_DEFINES_SVH
`define PROC_DEFINES_SVH

`define PROC_WORD_W 16
`define PROC_REG_SEL_W 3
`define PROC_NUM_REGS 8
`define PROC_OPCODE_W 5
`define PROC_IMM5_W 5
`define PROC_IMM8_W 8
`define PROC_FUNCT_W 2

// Field positions, low bit of each
`define PROC_OPC_LSB 11
`define PROC_RS_LSB 8
`define PROC_RT_LSB 5
`define PROC_RD_LSB 2

`define PROC_PC_STEP 2
`define PROC_RESET_PC 0

`endif

/* logic/proc_pkg.sv */
// ####################
// Processor package
// Word types and the enums shared by the pipeline stages
// ####################
`include "proc_defines.svh"

package proc_pkg;

	typedef logic [`PROC_WORD_W-1:0] word_t;
	typedef logic [`PROC_WORD_W-1:0] instr_t;
	typedef logic [`PROC_REG_SEL_W-1:0] reg_sel_t;

	// Opcodes still implemented
	typedef enum logic [`PROC_OPCODE_W-1:0] {
		OP_HALT = 5'b00000,
		OP_NOP = 5'b00001,
		OP_ADDI = 5'b01000,
		OP_SUBI = 5'b01001,
		OP_SLBI = 5'b10010,
		OP_LBI = 5'b11000,
		OP_RTYPE = 5'b11011
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_RSUB,
		ALU_XOR,
		ALU_ANDN,
		ALU_PASS_B,
		ALU_SLBI
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_MEM,
		FWD_WB
	} fwd_sel_e;

	typedef enum logic {
		FETCH_RUN,
		FETCH_FROZEN
	} fetch_state_e;

endpackage

/* logic/reg_file.sv */
// ####################
// Register file
// Eight registers, writes pass straight through to same-cycle reads
// ####################
`timescale 1ns/1ps
`include "proc_defines.svh"

module reg_file (
	input logic clk,
	input logic rst_n,
	input proc_pkg::reg_sel_t rs_sel,
	input proc_pkg::reg_sel_t rt_sel,
	input logic wb_en,
	input proc_pkg::reg_sel_t wb_reg,
	input proc_pkg::word_t wb_data,
	output proc_pkg::word_t rs_data,
	output proc_pkg::word_t rt_data
);

	proc_pkg::word_t regs [`PROC_NUM_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `PROC_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// Bypass covers a producer three slots ahead
	assign rs_data = (wb_en && wb_reg == rs_sel) ? wb_data : regs[rs_sel];
	assign rt_data = (wb_en && wb_reg == rt_sel) ? wb_data : regs[rt_sel];

endmodule

/* logic/retire_stage.sv */
// ####################
// Retire stage
// Memory/writeback register and the sticky halt flag
// ####################
`timescale 1ns/1ps
`include "proc_defines.svh"

module retire_stage (
	input logic clk,
	input logic rst_n,
	input logic m_wr_en,
	input proc_pkg::reg_sel_t m_rd,
	input proc_pkg::word_t m_result,
	input logic m_halt,
	output logic wb_en,
	output proc_pkg::reg_sel_t wb_reg,
	output proc_pkg::word_t wb_data,
	output logic halted
);

	// HALT sitting in the writeback slot
	logic w_halt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_en <= 1'b0;
			wb_reg <= '0;
			w_halt <= 1'b0;
			halted <= 1'b0;
		end else begin
			wb_en <= m_wr_en;
			wb_reg <= m_rd;
			w_halt <= m_halt;
			// Set as HALT leaves, held until reset
			if (w_halt) begin
				halted <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		wb_data <= m_result;
	end

endmodule

/* proc.f */
+incdir+logic
logic/proc_pkg.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/reg_file.sv
logic/forward_unit.sv
logic/execute_stage.sv
logic/retire_stage.sv
logic/proc.sv
bench/proc_assertions.sv
bench/proc_tb.sv
